/* Bender.yml */
package:
  name: shader_core

sources:
  - include_dirs:
      - .
    files:
      - shader_pkg.sv
      - shader_decode.sv
      - shader_register_file.sv
      - shader_execute.sv
      - shader_sequencer.sv
      - shader_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_shader_core.sv

/* build.f */
+incdir+.
shader_pkg.sv
shader_decode.sv
shader_register_file.sv
shader_execute.sv
shader_sequencer.sv
shader_core.sv
tb_shader_core.sv

/* shader_consts.svh */
`ifndef SHADER_CONSTS_SVH
`define SHADER_CONSTS_SVH

// Data path and instruction word width
`define SHADER_WORD_WIDTH 32

// Address width of both the instruction RAM and the data RAM
`define SHADER_RAM_ADDRESS_WIDTH 16

// Integer register number width for 32 registers
`define SHADER_REG_ADDRESS_WIDTH 5

// Byte distance from one instruction to the next
`define SHADER_PC_STEP 4

// Immediate of the system instruction that stops the core
`define SHADER_HALT_IMM 1

`endif

/* shader_core.sv */
`include "shader_consts.svh"

module shader_core (
    input  logic                                 clock,
    input  logic                                 reset_n,
    input  logic                                 run,
    output logic                                 halted,
    output logic [`SHADER_RAM_ADDRESS_WIDTH-1:0] inst_ram_address,
    input  logic [`SHADER_WORD_WIDTH-1:0]        inst_ram_read_result,
    output logic [`SHADER_RAM_ADDRESS_WIDTH-1:0] data_ram_address,
    output logic [`SHADER_WORD_WIDTH-1:0]        data_ram_write_data,
    output logic                                 data_ram_write,
    input  logic [`SHADER_WORD_WIDTH-1:0]        data_ram_read_result
);

    logic [`SHADER_WORD_WIDTH-1:0] instruction;
    logic [`SHADER_WORD_WIDTH-1:0] pc;
    shader_pkg::inst_class_t inst_class;
    shader_pkg::alu_op_t alu_op;
    logic [`SHADER_REG_ADDRESS_WIDTH-1:0] rs1;
    logic [`SHADER_REG_ADDRESS_WIDTH-1:0] rs2;
    logic [`SHADER_REG_ADDRESS_WIDTH-1:0] rd;
    logic [2:0] funct3;
    logic [`SHADER_WORD_WIDTH-1:0] immediate;
    logic [`SHADER_WORD_WIDTH-1:0] rs1_value;
    logic [`SHADER_WORD_WIDTH-1:0] rs2_value;
    logic [`SHADER_WORD_WIDTH-1:0] alu_result;
    logic branch_taken;
    logic rd_write;
    logic [`SHADER_REG_ADDRESS_WIDTH-1:0] rd_address;
    logic [`SHADER_WORD_WIDTH-1:0] rd_value;

    shader_sequencer sequencer_inst (
        .clock(clock), .reset_n(reset_n), .run(run), .halted(halted),
        .inst_ram_address(inst_ram_address), .inst_ram_read_result(inst_ram_read_result),
        .instruction(instruction), .pc(pc), .inst_class(inst_class), .rd(rd),
        .alu_result(alu_result), .branch_taken(branch_taken), .rs2_value(rs2_value),
        .data_ram_address(data_ram_address), .data_ram_write_data(data_ram_write_data),
        .data_ram_write(data_ram_write), .data_ram_read_result(data_ram_read_result),
        .rd_write(rd_write), .rd_address(rd_address), .rd_value(rd_value)
    );

    shader_decode decode_inst (
        .instruction(instruction), .inst_class(inst_class), .rs1(rs1), .rs2(rs2),
        .rd(rd), .funct3(funct3), .immediate(immediate), .alu_op(alu_op)
    );

    shader_register_file register_file_inst (
        .clock(clock), .rs1(rs1), .rs2(rs2), .rs1_value(rs1_value), .rs2_value(rs2_value),
        .rd_write(rd_write), .rd_address(rd_address), .rd_value(rd_value)
    );

    shader_execute execute_inst (
        .inst_class(inst_class), .alu_op(alu_op), .funct3(funct3), .immediate(immediate),
        .pc(pc), .rs1_value(rs1_value), .rs2_value(rs2_value),
        .alu_result(alu_result), .branch_taken(branch_taken)
    );

endmodule

/* shader_decode.sv */
`include "shader_consts.svh"

module shader_decode (
    input  logic [`SHADER_WORD_WIDTH-1:0]        instruction,
    output shader_pkg::inst_class_t              inst_class,
    output logic [`SHADER_REG_ADDRESS_WIDTH-1:0] rs1,
    output logic [`SHADER_REG_ADDRESS_WIDTH-1:0] rs2,
    output logic [`SHADER_REG_ADDRESS_WIDTH-1:0] rd,
    output logic [2:0]                           funct3,
    output logic [`SHADER_WORD_WIDTH-1:0]        immediate,
    output shader_pkg::alu_op_t                  alu_op
);

    logic [6:0] opcode;
    logic [`SHADER_WORD_WIDTH-1:0] imm_i;
    logic [`SHADER_WORD_WIDTH-1:0] imm_s;
    logic [`SHADER_WORD_WIDTH-1:0] imm_b;
    logic [`SHADER_WORD_WIDTH-1:0] imm_u;
    logic [`SHADER_WORD_WIDTH-1:0] imm_j;
    shader_pkg::alu_op_t funct_op;

    assign opcode = instruction[6:0];
    assign rd = instruction[11:7];
    assign funct3 = instruction[14:12];
    assign rs1 = instruction[19:15];
    assign rs2 = instruction[24:20];

    // Sign extended immediates of every format
    assign imm_i = {{20{instruction[31]}}, instruction[31:20]};
    assign imm_s = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign imm_b = {{19{instruction[31]}}, instruction[31], instruction[7],
                    instruction[30:25], instruction[11:8], 1'b0};
    assign imm_u = {instruction[31:12], 12'b0};
    assign imm_j = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                    instruction[20], instruction[30:21], 1'b0};

    always_comb begin
        case (opcode)
            7'b0010011: inst_class = shader_pkg::class_alu_imm;
            7'b0110011: inst_class = shader_pkg::class_alu_reg;
            7'b0110111: inst_class = shader_pkg::class_lui;
            7'b1101111: inst_class = shader_pkg::class_jal;
            7'b1100111: inst_class = shader_pkg::class_jalr;
            7'b1100011: inst_class = shader_pkg::class_branch;
            7'b0000011: inst_class = shader_pkg::class_load;
            7'b0100011: inst_class = shader_pkg::class_store;
            7'b1110011: begin
                // Only the halting system call is supported
                if (instruction[31:20] == `SHADER_HALT_IMM) begin
                    inst_class = shader_pkg::class_halt;
                end else begin
                    inst_class = shader_pkg::class_illegal;
                end
            end
            default: inst_class = shader_pkg::class_illegal;
        endcase
    end

    always_comb begin
        case (inst_class)
            shader_pkg::class_store:  immediate = imm_s;
            shader_pkg::class_branch: immediate = imm_b;
            shader_pkg::class_lui:    immediate = imm_u;
            shader_pkg::class_jal:    immediate = imm_j;
            shader_pkg::class_alu_reg: immediate = '0;
            default:                  immediate = imm_i;
        endcase
    end

    // Bit 30 picks sub over add for registers and sra over srl for both forms
    always_comb begin
        case (funct3)
            3'b000: begin
                if (inst_class == shader_pkg::class_alu_reg && instruction[30]) begin
                    funct_op = shader_pkg::alu_sub;
                end else begin
                    funct_op = shader_pkg::alu_add;
                end
            end
            3'b001: funct_op = shader_pkg::alu_sll;
            3'b010: funct_op = shader_pkg::alu_slt;
            3'b011: funct_op = shader_pkg::alu_sltu;
            3'b100: funct_op = shader_pkg::alu_xor;
            3'b101: funct_op = instruction[30] ? shader_pkg::alu_sra : shader_pkg::alu_srl;
            3'b110: funct_op = shader_pkg::alu_or;
            default: funct_op = shader_pkg::alu_and;
        endcase
    end

    always_comb begin
        case (inst_class)
            shader_pkg::class_alu_imm,
            shader_pkg::class_alu_reg: alu_op = funct_op;
            // Address and target arithmetic
            shader_pkg::class_jal,
            shader_pkg::class_jalr,
            shader_pkg::class_branch,
            shader_pkg::class_load,
            shader_pkg::class_store:   alu_op = shader_pkg::alu_add;
            default:                   alu_op = shader_pkg::alu_none;
        endcase
    end

endmodule

/* shader_execute.sv */
`include "shader_consts.svh"

module shader_execute (
    input  shader_pkg::inst_class_t       inst_class,
    input  shader_pkg::alu_op_t           alu_op,
    input  logic [2:0]                    funct3,
    input  logic [`SHADER_WORD_WIDTH-1:0] immediate,
    input  logic [`SHADER_WORD_WIDTH-1:0] pc,
    input  logic [`SHADER_WORD_WIDTH-1:0] rs1_value,
    input  logic [`SHADER_WORD_WIDTH-1:0] rs2_value,
    output logic [`SHADER_WORD_WIDTH-1:0] alu_result,
    output logic                          branch_taken
);

    logic [`SHADER_WORD_WIDTH-1:0] operand1;
    logic [`SHADER_WORD_WIDTH-1:0] operand2;
    logic [4:0] shift_amount;
    logic less_signed;
    logic less_unsigned;

    always_comb begin
        case (inst_class)
            shader_pkg::class_jal,
            shader_pkg::class_branch: operand1 = pc;
            shader_pkg::class_lui:    operand1 = immediate;
            default:                  operand1 = rs1_value;
        endcase
    end

    assign operand2 = (inst_class == shader_pkg::class_alu_reg) ? rs2_value : immediate;

    // Low five bits serve both the rs2 shift and the I-type shamt field
    assign shift_amount = operand2[4:0];

    assign less_signed = $signed(operand1) < $signed(operand2);
    assign less_unsigned = operand1 < operand2;

    always_comb begin
        case (alu_op)
            shader_pkg::alu_add:  alu_result = operand1 + operand2;
            shader_pkg::alu_sub:  alu_result = operand1 - operand2;
            shader_pkg::alu_sll:  alu_result = operand1 << shift_amount;
            shader_pkg::alu_srl:  alu_result = operand1 >> shift_amount;
            shader_pkg::alu_sra:  alu_result = $signed(operand1) >>> shift_amount;
            shader_pkg::alu_xor:  alu_result = operand1 ^ operand2;
            shader_pkg::alu_and:  alu_result = operand1 & operand2;
            shader_pkg::alu_or:   alu_result = operand1 | operand2;
            shader_pkg::alu_slt:  alu_result = {{(`SHADER_WORD_WIDTH-1){1'b0}}, less_signed};
            shader_pkg::alu_sltu: alu_result = {{(`SHADER_WORD_WIDTH-1){1'b0}}, less_unsigned};
            // lui and anything without an operation
            default:              alu_result = operand1;
        endcase
    end

    // Branch comparison always works on the two source registers
    always_comb begin
        case (funct3)
            3'b000:  branch_taken = rs1_value == rs2_value;
            3'b001:  branch_taken = rs1_value != rs2_value;
            3'b100:  branch_taken = $signed(rs1_value) < $signed(rs2_value);
            3'b101:  branch_taken = $signed(rs1_value) >= $signed(rs2_value);
            3'b110:  branch_taken = rs1_value < rs2_value;
            3'b111:  branch_taken = rs1_value >= rs2_value;
            default: branch_taken = 1'b0;
        endcase
    end

endmodule

/* shader_pkg.sv */
`include "shader_consts.svh"

package shader_pkg;

    // Sequencer states that each last one clock while run is high
    typedef enum logic [3:0] {
        state_fetch,
        state_fetch_wait,
        state_decode,
        state_execute,
        state_load,
        state_load_wait,
        state_store,
        state_retire,
        state_halted
    } core_state_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_xor,
        alu_and,
        alu_or,
        alu_slt,
        alu_sltu,
        alu_none
    } alu_op_t;

    // Instruction classes recognised by the decoder
    typedef enum logic [3:0] {
        class_alu_imm,
        class_alu_reg,
        class_lui,
        class_jal,
        class_jalr,
        class_branch,
        class_load,
        class_store,
        class_halt,
        class_illegal
    } inst_class_t;

endpackage

/* shader_register_file.sv */
`include "shader_consts.svh"

module shader_register_file (
    input  logic                                 clock,
    input  logic [`SHADER_REG_ADDRESS_WIDTH-1:0] rs1,
    input  logic [`SHADER_REG_ADDRESS_WIDTH-1:0] rs2,
    output logic [`SHADER_WORD_WIDTH-1:0]        rs1_value,
    output logic [`SHADER_WORD_WIDTH-1:0]        rs2_value,
    input  logic                                 rd_write,
    input  logic [`SHADER_REG_ADDRESS_WIDTH-1:0] rd_address,
    input  logic [`SHADER_WORD_WIDTH-1:0]        rd_value
);

    logic [`SHADER_WORD_WIDTH-1:0] registers [2**`SHADER_REG_ADDRESS_WIDTH];

    // x0 is hard wired to zero, so writes to it are dropped
    always_ff @(posedge clock) begin
        if (rd_write && rd_address != '0) begin
            registers[rd_address] <= rd_value;
        end
    end

    assign rs1_value = (rs1 == '0) ? '0 : registers[rs1];
    assign rs2_value = (rs2 == '0) ? '0 : registers[rs2];

    // The sequencer latches rd in execute, well before the retire write
    rd_address_known: assert property (
        @(posedge clock) rd_write |-> !$isunknown(rd_address)
    ) else $error("register write with unknown destination");

endmodule

/* shader_sequencer.sv */
`include "shader_consts.svh"

module shader_sequencer (
    input  logic                                 clock,
    input  logic                                 reset_n,
    input  logic                                 run,
    output logic                                 halted,
    output logic [`SHADER_RAM_ADDRESS_WIDTH-1:0] inst_ram_address,
    input  logic [`SHADER_WORD_WIDTH-1:0]        inst_ram_read_result,
    output logic [`SHADER_WORD_WIDTH-1:0]        instruction,
    output logic [`SHADER_WORD_WIDTH-1:0]        pc,
    input  shader_pkg::inst_class_t              inst_class,
    input  logic [`SHADER_REG_ADDRESS_WIDTH-1:0] rd,
    input  logic [`SHADER_WORD_WIDTH-1:0]        alu_result,
    input  logic                                 branch_taken,
    input  logic [`SHADER_WORD_WIDTH-1:0]        rs2_value,
    output logic [`SHADER_RAM_ADDRESS_WIDTH-1:0] data_ram_address,
    output logic [`SHADER_WORD_WIDTH-1:0]        data_ram_write_data,
    output logic                                 data_ram_write,
    input  logic [`SHADER_WORD_WIDTH-1:0]        data_ram_read_result,
    output logic                                 rd_write,
    output logic [`SHADER_REG_ADDRESS_WIDTH-1:0] rd_address,
    output logic [`SHADER_WORD_WIDTH-1:0]        rd_value
);

    shader_pkg::core_state_t state;
    logic is_jump;
    logic writes_rd;
    logic [`SHADER_WORD_WIDTH-1:0] pc_plus_step;

    assign is_jump = inst_class == shader_pkg::class_jal ||
                     inst_class == shader_pkg::class_jalr;
    assign pc_plus_step = pc + `SHADER_PC_STEP;

    always_comb begin
        case (inst_class)
            shader_pkg::class_alu_imm,
            shader_pkg::class_alu_reg,
            shader_pkg::class_lui,
            shader_pkg::class_jal,
            shader_pkg::class_jalr,
            shader_pkg::class_load: writes_rd = 1'b1;
            default:                writes_rd = 1'b0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state <= shader_pkg::state_fetch;
            pc <= '0;
            halted <= 1'b0;
            data_ram_write <= 1'b0;
            rd_write <= 1'b0;
        end else if (run) begin
            case (state)
                shader_pkg::state_fetch: begin
                    rd_write <= 1'b0;
                    inst_ram_address <= pc[`SHADER_RAM_ADDRESS_WIDTH-1:0];
                    state <= shader_pkg::state_fetch_wait;
                end
                // RAM read data shows up one clock after the address
                shader_pkg::state_fetch_wait: state <= shader_pkg::state_decode;
                shader_pkg::state_decode: begin
                    instruction <= inst_ram_read_result;
                    state <= shader_pkg::state_execute;
                end
                shader_pkg::state_execute: begin
                    rd_address <= rd;
                    halted <= inst_class == shader_pkg::class_halt;
                    if (inst_class == shader_pkg::class_halt) begin
                        state <= shader_pkg::state_halted;
                    end else if (inst_class == shader_pkg::class_load) begin
                        state <= shader_pkg::state_load;
                    end else if (inst_class == shader_pkg::class_store) begin
                        state <= shader_pkg::state_store;
                    end else begin
                        state <= shader_pkg::state_retire;
                    end
                end
                shader_pkg::state_load: begin
                    data_ram_address <= alu_result[`SHADER_RAM_ADDRESS_WIDTH-1:0];
                    state <= shader_pkg::state_load_wait;
                end
                shader_pkg::state_load_wait: state <= shader_pkg::state_retire;
                shader_pkg::state_store: begin
                    data_ram_address <= alu_result[`SHADER_RAM_ADDRESS_WIDTH-1:0];
                    data_ram_write_data <= rs2_value;
                    data_ram_write <= 1'b1;
                    state <= shader_pkg::state_retire;
                end
                shader_pkg::state_retire: begin
                    data_ram_write <= 1'b0;
                    rd_write <= writes_rd;
                    if (is_jump) begin
                        rd_value <= pc_plus_step;
                    end else if (inst_class == shader_pkg::class_load) begin
                        rd_value <= data_ram_read_result;
                    end else begin
                        rd_value <= alu_result;
                    end
                    // Jump targets are forced to an even address
                    if (is_jump) begin
                        pc <= {alu_result[`SHADER_WORD_WIDTH-1:1], 1'b0};
                    end else if (inst_class == shader_pkg::class_branch && branch_taken) begin
                        pc <= alu_result;
                    end else begin
                        pc <= pc_plus_step;
                    end
                    state <= shader_pkg::state_fetch;
                end
                // Only reset leaves this state
                shader_pkg::state_halted: state <= shader_pkg::state_halted;
                default: state <= shader_pkg::state_fetch;
            endcase
        end
    end

    // A store strobe lasts one running cycle, stretched only by run low
    store_strobe_single: assert property (
        @(posedge clock) disable iff (!reset_n)
        data_ram_write && run |=> !data_ram_write
    ) else $error("data_ram_write held for more than one cycle");

    halt_is_sticky: assert property (
        @(posedge clock) disable iff (!reset_n) halted |=> halted
    ) else $error("halted fell without reset");

endmodule

/* tb_shader_core.sv */
`include "shader_consts.svh"

module tb_shader_core;
    timeunit 1ns;
    timeprecision 1ps;

    logic                                 clock;
    logic                                 reset_n;
    logic                                 run;
    logic                                 halted;
    logic [`SHADER_RAM_ADDRESS_WIDTH-1:0] inst_ram_address;
    logic [`SHADER_WORD_WIDTH-1:0]        inst_ram_read_result = '0;
    logic [`SHADER_RAM_ADDRESS_WIDTH-1:0] data_ram_address;
    logic [`SHADER_WORD_WIDTH-1:0]        data_ram_write_data;
    logic                                 data_ram_write;
    logic [`SHADER_WORD_WIDTH-1:0]        data_ram_read_result = '0;

    // Word addressed models of 4 KB each
    logic [`SHADER_WORD_WIDTH-1:0] inst_mem [1024];
    logic [`SHADER_WORD_WIDTH-1:0] data_mem [1024];

    logic [`SHADER_WORD_WIDTH-1:0] expected_address [$];
    logic [`SHADER_WORD_WIDTH-1:0] expected_data [$];
    int seed;
    int errors;
    int tests_passed;
    int tests_failed;

    shader_core shader_core_inst (
        .clock(clock), .reset_n(reset_n), .run(run), .halted(halted),
        .inst_ram_address(inst_ram_address), .inst_ram_read_result(inst_ram_read_result),
        .data_ram_address(data_ram_address), .data_ram_write_data(data_ram_write_data),
        .data_ram_write(data_ram_write), .data_ram_read_result(data_ram_read_result)
    );

    initial clock = 1'b0;
    always #2 clock = ~clock;

    // One clock of registered read latency on both RAMs
    always @(posedge clock) begin
        inst_ram_read_result <= inst_mem[inst_ram_address[11:2]];
        data_ram_read_result <= data_mem[data_ram_address[11:2]];
        if (data_ram_write) begin
            data_mem[data_ram_address[11:2]] <= data_ram_write_data;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    // Opcode bits stay zero in the instruction fill, so stray words retire as no-ops
    task automatic clear_memories();
        for (int i = 0; i < 1024; i++) begin
            inst_mem[i] = i << 16;
            data_mem[i] = 32'hD0D00000 | i;
        end
        expected_address.delete();
        expected_data.delete();
    endtask

    task automatic run_test(input string name);
        int errors_before;
        int cycles;
        int pause_start;
        int pause_length;
        int late_writes;
        errors_before = errors;
        pause_start = 4 + ($random(seed) & 32'h1F);
        pause_length = 1 + ($random(seed) & 32'h0F);
        reset_n = 1'b0;
        run = 1'b0;
        repeat (16) @(negedge clock);
        reset_n = 1'b1;
        run = 1'b1;
        cycles = 0;
        while (!halted && cycles < 2000) begin
            @(negedge clock);
            if (cycles == pause_start) run = 1'b0;
            if (cycles == pause_start + pause_length) run = 1'b1;
            cycles++;
        end
        run = 1'b1;
        if (!halted) begin
            $display("test %s: the core never halted within 2000 cycles", name);
            errors++;
        end else begin
            late_writes = 0;
            for (int i = 0; i < 50; i++) begin
                @(negedge clock);
                if (data_ram_write) late_writes++;
                if (!halted) begin
                    $display("test %s: halted dropped after the core stopped", name);
                    errors++;
                end
            end
            if (late_writes != 0) begin
                $display("test %s: data RAM written %0d times after halt", name, late_writes);
                errors++;
            end
            foreach (expected_address[k]) begin
                check_value($sformatf("%s word %h", name, expected_address[k]),
                            expected_data[k], data_mem[expected_address[k][11:2]]);
            end
        end
        if (errors == errors_before) begin
            tests_passed++;
            $display("test %s: ok after %0d cycles", name, cycles);
        end else begin
            tests_failed++;
            $display("test %s: failed", name);
        end
    endtask

    initial begin
        int fd;
        string token;
        string name;
        string line;
        logic [31:0] address;
        logic [31:0] word;
        seed = 85379;
        errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        reset_n = 1'b0;
        run = 1'b0;
        name = "none";
        clear_memories();
        fd = $fopen("tb_shader_input.txt", "r");
        if (fd == 0) begin
            $display("could not open tb_shader_input.txt");
            errors++;
        end else begin
            while ($fscanf(fd, "%s", token) == 1) begin
                if (token == "#") begin
                    void'($fgets(line, fd));
                end else if (token == "test") begin
                    void'($fscanf(fd, "%s", name));
                    clear_memories();
                end else if (token == "i") begin
                    void'($fscanf(fd, "%h %h", address, word));
                    inst_mem[address[11:2]] = word;
                end else if (token == "d") begin
                    void'($fscanf(fd, "%h %h", address, word));
                    data_mem[address[11:2]] = word;
                end else if (token == "e") begin
                    void'($fscanf(fd, "%h %h", address, word));
                    expected_address.push_back(address);
                    expected_data.push_back(word);
                end else if (token == "end") begin
                    run_test(name);
                end else begin
                    $display("unknown token %s in input file", token);
                    errors++;
                end
            end
            $fclose(fd);
        end
        $display("tests passed %0d failed %0d errors %0d", tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0 && tests_passed > 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* tb_shader_input.txt */
# kind address word: i instruction, d data preload, e expected data word
# test name opens a program, end runs it
test alu
d 200 12345678
d 204 0F0F00FF
i 000 20002083
i 004 20402103
i 008 002081B3
i 00C 40208233
i 010 0020C2B3
i 014 0020E333
i 018 0020F3B3
i 01C FFB08413
i 020 ABCDE537
i 024 12356513
i 028 0F00F593
i 02C 30302023
i 030 30402223
i 034 30502423
i 038 30602623
i 03C 30702823
i 040 30802A23
i 044 30A02C23
i 048 30B02E23
i 04C 00100073
e 300 21435777
e 304 03255579
e 308 1D3B5687
e 30C 1F3F56FF
e 310 02040078
e 314 12345673
e 318 ABCDE123
e 31C 00000070
end
test shift_compare
d 200 80000010
d 204 00000024
i 000 20002083
i 004 20402103
i 008 00409193
i 00C 0040D213
i 010 4040D293
i 014 00209333
i 018 0020D3B3
i 01C 4020D433
i 020 0020A4B3
i 024 0020B533
i 028 30302023
i 02C 30402223
i 030 30502423
i 034 30602623
i 038 30702823
i 03C 30802A23
i 040 30902C23
i 044 30A02E23
i 048 00100073
e 300 00000100
e 304 08000001
e 308 F8000001
e 30C 00000100
e 310 08000001
e 314 F8000001
e 318 00000001
e 31C 00000000
end
test memory_x0
d 200 CAFEF00D
d 304 FFFFFFFF
i 000 20002083
i 004 30102023
i 008 00008013
i 00C 30002223
i 010 00100073
e 300 CAFEF00D
e 304 00000000
end
test control_flow
i 000 00000193
i 004 00500093
i 008 FFD00113
i 00C 00208463
i 010 0011E193
i 014 00209463
i 018 0021E193
i 01C 0020C463
i 020 0041E193
i 024 0020D463
i 028 0081E193
i 02C 0020E463
i 030 0101E193
i 034 0020F463
i 038 0201E193
i 03C 30302023
i 040 00C0026F
i 044 00100073
i 04C 05C002E7
i 050 00100073
i 05C 30402223
i 060 30502423
i 064 00100073
e 300 00000025
e 304 00000044
e 308 00000050
end
